//--- design/ma_pkg.sv
// Single-copy MA stage constants; control-bit order must match the EX stage encoding
`default_nettype none

package ma_pkg;

    // Datapath widths
    localparam int XLEN      = 32;                 // Data and address width
    localparam int ICTRL_W   = 7;                  // Instruction control word
    localparam int RF_ADD_W  = 5;                  // Register file address
    localparam int FUNC_W    = 3;                  // Function field
    localparam int LD_INFO_W = FUNC_W + 2;         // Load function plus byte offset
    localparam int TAG_W     = XLEN - 1;           // Predicted target, bits 31:1

    // Bit positions inside the instruction control word
    // An all-zero word marks an empty slot
    localparam int ICTRL_RVC      = 0;             // Compressed instruction
    localparam int ICTRL_REG_DEST = 1;             // Writes the register file
    localparam int ICTRL_UNIT_ALU = 2;
    localparam int ICTRL_UNIT_BRU = 3;
    localparam int ICTRL_UNIT_LSU = 4;
    localparam int ICTRL_UNIT_MDU = 5;
    localparam int ICTRL_UNIT_CSR = 6;

    // BRU function code of a conditional branch
    // Every other code on a BRU slot is treated as a jump
    localparam logic [FUNC_W-1:0] BRU_F_BRANCH = 3'b000;

    // Load function codes, same as RISC-V funct3
    localparam logic [FUNC_W-1:0] LD_LB  = 3'b000;
    localparam logic [FUNC_W-1:0] LD_LH  = 3'b001;
    localparam logic [FUNC_W-1:0] LD_LW  = 3'b010;
    localparam logic [FUNC_W-1:0] LD_LBU = 3'b100;
    localparam logic [FUNC_W-1:0] LD_LHU = 3'b101;

endpackage

`default_nettype wire

//--- design/load_extender.sv
// Load data alignment; misaligned halfwords are not checked, unknown codes pass the word
`timescale 1ns/1ns
`default_nettype none

module load_extender
    import ma_pkg::*;
(
    input  logic [XLEN-1:0]      word_i,       // Raw bus word
    input  logic [LD_INFO_W-1:0] ld_info_i,    // {function, offset}
    output logic [XLEN-1:0]      data_o        // Extended result
);

    logic [FUNC_W-1:0] func;
    logic [1:0]        offset;
    logic [7:0]        byte_sel;
    logic [15:0]       half_sel;

    assign func   = ld_info_i[LD_INFO_W-1:2];
    assign offset = ld_info_i[1:0];

    // Little-endian lane pick
    assign byte_sel = word_i[offset*8 +: 8];
    assign half_sel = offset[1] ? word_i[31:16] : word_i[15:0];

    always_comb begin
        case (func)
            LD_LB:   data_o = {{24{byte_sel[7]}}, byte_sel};
            LD_LH:   data_o = {{16{half_sel[15]}}, half_sel};
            LD_LBU:  data_o = {24'd0, byte_sel};
            LD_LHU:  data_o = {16'd0, half_sel};
            LD_LW:   data_o = word_i;
            default: data_o = word_i;
        endcase
    end

endmodule

`default_nettype wire

//--- design/ma_control.sv
// MA stage control; interrupt is a level taken only on non-LSU slots, no CSR or trap return
`timescale 1ns/1ns
`default_nettype none

module ma_control
    import ma_pkg::*;
(
    input  logic               s_clk_i,        // Core clock
    input  logic               arst_n_i,       // Async reset, active low
    input  logic               int_meip_i,     // Machine external interrupt level
    input  logic               lsu_ready_i,    // Data-bus transfer finished
    input  logic [ICTRL_W-1:0] exma_ictrl_i,   // Control word of the MA slot
    input  logic               bru_taken_i,    // Branch or jump taken
    input  logic               bru_toc_i,      // Misprediction, redirect needed
    input  logic [ICTRL_W-1:0] mawb_ictrl_i,   // Control word held in WB

    output logic               stall_o,        // Stall lower stages
    output logic               flush_o,        // Flush lower stages
    output logic               hold_o,         // Keep EX from starting new work
    output logic               take_int_o,     // Interrupt accepted this cycle
    output logic               take_branch_o,  // Taken branch in a live slot
    output logic               toc_valid_o,    // Transfer address is the new PC
    output logic               pc_we_o,        // PC register write enable
    output logic               kill_o,         // Zero the WB control word
    output logic               we_aux_o,       // Enable for rd and load info
    output logic               we_val_o,       // Enable for result value
    output logic               we_esn_o        // Enable for WB control word
);

    logic ma_empty;                            // Nothing in the MA slot
    logic is_lsu;
    logic stall_ma;
    logic flush_ma;
    logic take_int;
    logic bubble_q;                            // Previous slot was killed

    assign ma_empty = (exma_ictrl_i == '0);
    assign is_lsu   = exma_ictrl_i[ICTRL_UNIT_LSU];

    // Bus transfer still running
    assign stall_ma = is_lsu & ~lsu_ready_i;

    // Interrupt waits for a load or store to complete
    assign take_int = int_meip_i & ~is_lsu;
    assign flush_ma = take_int;                // MA instruction dropped on interrupt

    assign stall_o       = stall_ma;
    assign flush_o       = take_int | bru_toc_i;
    assign hold_o        = int_meip_i;         // Pending interrupt blocks EX
    assign take_int_o    = take_int;
    assign take_branch_o = bru_taken_i & ~flush_ma;

    // PC moves on any accepted slot, or to the trap address
    assign pc_we_o     = (~ma_empty & ~stall_ma) | take_int;
    assign toc_valid_o = pc_we_o;              // Same condition selects the new PC as target

    assign kill_o   = flush_ma | stall_ma;
    assign we_aux_o = ~(flush_ma | ma_empty);
    // Load data is captured only in the ready cycle
    assign we_val_o = we_aux_o & (~is_lsu | lsu_ready_i);

    // Remember a killed slot so the zero word is written once more
    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bubble_q <= 1'b0;
        end else begin
            bubble_q <= kill_o;
        end
    end

    // Write the control word while something is live in MA or WB
    assign we_esn_o = flush_ma | ~ma_empty | (mawb_ictrl_i != '0) | bubble_q;

endmodule

`default_nettype wire

//--- design/ma_branch_resolver.sv
// Branch outcome check; one predictor entry per BRU slot, target must be halfword aligned
`timescale 1ns/1ns
`default_nettype none

module ma_branch_resolver
    import ma_pkg::*;
(
    input  logic [ICTRL_W-1:0] exma_ictrl_i,   // Control word of the MA slot
    input  logic [FUNC_W-1:0]  exma_f_i,       // BRU function
    input  logic [XLEN-1:0]    exma_val_i,     // Target, bit 0 is the condition
    input  logic               exma_pred_i,    // Instruction was predicted at fetch
    input  logic [TAG_W-1:0]   bop_tadd_i,     // Stored predicted target
    input  logic               bop_pred_i,     // Predictor entry valid
    input  logic               kill_i,         // Slot flushed or stalled

    output logic               bru_taken_o,    // Branch or jump taken
    output logic               bru_toc_o,      // Redirect on misprediction
    output logic [XLEN-1:0]    bru_target_o,   // Resolved target address
    output logic               bop_pop_o,      // Release predictor entry
    output logic               pred_btbu_o,    // Update target buffer
    output logic               pred_btrue_o,   // Branch condition met
    output logic               pred_bpu_o,     // Update branch predictor
    output logic               pred_jpu_o      // Update jump predictor
);

    logic is_bru;
    logic is_branch;
    logic taken;
    logic predicted;
    logic tgt_miss;                            // Stored target differs
    logic active;                              // Live BRU slot

    assign is_bru    = exma_ictrl_i[ICTRL_UNIT_BRU];
    assign is_branch = (exma_f_i == BRU_F_BRANCH);

    // Condition bit is replaced by 0 in the real target
    assign bru_target_o = {exma_val_i[XLEN-1:1], 1'b0};

    // Jumps are always taken
    assign taken     = is_branch ? exma_val_i[0] : 1'b1;
    assign predicted = exma_pred_i & bop_pred_i;
    assign tgt_miss  = (bop_tadd_i != exma_val_i[XLEN-1:1]);

    assign bru_taken_o = is_bru & taken;

    // Wrong direction, or right direction with wrong address
    assign bru_toc_o = is_bru & ((taken != predicted) | (taken & predicted & tgt_miss));

    assign active = is_bru & ~kill_i;

    assign pred_bpu_o   = active & is_branch;
    assign pred_btrue_o = active & is_branch & taken;
    assign pred_jpu_o   = active & ~is_branch;
    // New target entry when the fetch had no or a stale one
    assign pred_btbu_o  = active & taken & (~predicted | tgt_miss);
    assign bop_pop_o    = active & exma_pred_i;

endmodule

`default_nettype wire

//--- design/ma_pc_unit.sv
// Program counter of the committed stream; boot address is sampled while reset is low
`timescale 1ns/1ns
`default_nettype none

module ma_pc_unit
    import ma_pkg::*;
#(
    parameter logic [XLEN-1:0] TRAP_ADDR = 32'h0000_0100  // Interrupt entry
) (
    input  logic            s_clk_i,           // Core clock
    input  logic            arst_n_i,          // Async reset, active low
    input  logic [XLEN-1:0] boot_addr_i,       // Reset value of the PC
    input  logic            rvc_i,             // Compressed instruction in MA
    input  logic            pc_we_i,           // Accept the new PC
    input  logic            take_int_i,        // Go to the trap address
    input  logic            take_branch_i,     // Go to the branch target
    input  logic            toc_valid_i,       // Target output shows the new PC
    input  logic [XLEN-1:0] bru_target_i,      // Resolved branch target

    output logic [XLEN-1:0] pc_o,              // Current PC
    output logic [XLEN-1:0] next_pc_o,         // Sequential successor
    output logic [XLEN-1:0] toc_addr_o         // Transfer-of-control address
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_incr;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] new_pc;

    assign pc_incr = rvc_i ? XLEN'(2) : XLEN'(4);
    assign next_pc = pc_q + pc_incr;

    // Interrupt wins over a taken branch
    always_comb begin
        if (take_int_i) begin
            new_pc = TRAP_ADDR;
        end else if (take_branch_i) begin
            new_pc = bru_target_i;
        end else begin
            new_pc = next_pc;
        end
    end

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= boot_addr_i;
        end else if (pc_we_i) begin
            pc_q <= new_pc;
        end
    end

    assign pc_o       = pc_q;
    assign next_pc_o  = next_pc;                // Link value for jumps
    assign toc_addr_o = toc_valid_i ? new_pc : pc_q;

endmodule

`default_nettype wire

//--- design/ma_wb_regs.sv
// MA/WB register set; load data is captured raw and extended in the WB cycle
`timescale 1ns/1ns
`default_nettype none

module ma_wb_regs
    import ma_pkg::*;
(
    input  logic                s_clk_i,       // Core clock
    input  logic                arst_n_i,      // Async reset, active low
    input  logic [ICTRL_W-1:0]  exma_ictrl_i,  // Control word of the MA slot
    input  logic [FUNC_W-1:0]   exma_f_i,      // Function, load type for LSU
    input  logic [RF_ADD_W-1:0] exma_rd_i,     // Destination register
    input  logic [XLEN-1:0]     exma_val_i,    // EX result or load address
    input  logic [XLEN-1:0]     lsu_data_i,    // Raw bus read word
    input  logic [XLEN-1:0]     next_pc_i,     // Link address for BRU
    input  logic                kill_i,        // Zero the control word
    input  logic                we_aux_i,      // Enable rd and load info
    input  logic                we_val_i,      // Enable result value
    input  logic                we_esn_i,      // Enable control word

    output logic [ICTRL_W-1:0]  mawb_ictrl_o,  // WB control word
    output logic [RF_ADD_W-1:0] mawb_rd_o,     // WB destination
    output logic [XLEN-1:0]     mawb_val_o     // WB result
);

    logic [XLEN-1:0]      result;
    logic [ICTRL_W-1:0]   ictrl_d;
    logic [LD_INFO_W-1:0] ldi_d;
    logic [ICTRL_W-1:0]   ictrl_q;
    logic [RF_ADD_W-1:0]  rd_q;
    logic [XLEN-1:0]      val_q;
    logic [LD_INFO_W-1:0] ldi_q;
    logic [XLEN-1:0]      ld_data;             // Extended load value

    always_comb begin
        if (exma_ictrl_i[ICTRL_UNIT_LSU]) begin
            result = lsu_data_i;
        end else if (exma_ictrl_i[ICTRL_UNIT_BRU]) begin
            result = next_pc_i;                // Return address
        end else begin
            result = exma_val_i;
        end
    end

    assign ictrl_d = kill_i ? '0 : exma_ictrl_i;   // Bubble into WB
    assign ldi_d   = {exma_f_i, exma_val_i[1:0]};  // Type and byte offset

    // Control word needs a known empty state
    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ictrl_q <= '0;
        end else if (we_esn_i) begin
            ictrl_q <= ictrl_d;
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (we_aux_i) begin
            rd_q  <= exma_rd_i;
            ldi_q <= ldi_d;
        end
        if (we_val_i) begin
            val_q <= result;
        end
    end

    load_extender u_load_extender (
        .word_i    (val_q),
        .ld_info_i (ldi_q),
        .data_o    (ld_data)
    );

    assign mawb_ictrl_o = ictrl_q;
    assign mawb_rd_o    = rd_q;
    assign mawb_val_o   = ictrl_q[ICTRL_UNIT_LSU] ? ld_data : val_q;

endmodule

`default_nettype wire

//--- design/ma_stage.sv
// MA stage top for one pipeline copy; EX must hold its outputs while stall_o is high
`timescale 1ns/1ns
`default_nettype none

module ma_stage
    import ma_pkg::*;
#(
    parameter logic [XLEN-1:0] TRAP_ADDR = 32'h0000_0100  // Interrupt entry
) (
    input  logic                s_clk_i,       // Core clock
    input  logic                arst_n_i,      // Async reset, active low
    input  logic [XLEN-1:0]     boot_addr_i,   // Reset PC
    input  logic                int_meip_i,    // External interrupt level
    input  logic [XLEN-1:0]     lsu_data_i,    // Bus read data
    input  logic                lsu_ready_i,   // Bus transfer done
    input  logic [ICTRL_W-1:0]  exma_ictrl_i,
    input  logic [FUNC_W-1:0]   exma_f_i,
    input  logic [RF_ADD_W-1:0] exma_rd_i,
    input  logic [XLEN-1:0]     exma_val_i,
    input  logic                exma_pred_i,   // Predicted at fetch
    input  logic [TAG_W-1:0]    bop_tadd_i,    // Predictor entry target
    input  logic                bop_pred_i,    // Predictor entry valid

    output logic                stall_o,
    output logic                flush_o,
    output logic                hold_o,
    output logic [XLEN-1:0]     toc_addr_o,    // Redirect address
    output logic [XLEN-1:0]     pc_o,
    output logic                bop_pop_o,
    output logic                pred_btbu_o,
    output logic                pred_btrue_o,
    output logic                pred_bpu_o,
    output logic                pred_jpu_o,
    output logic [ICTRL_W-1:0]  mawb_ictrl_o,
    output logic [RF_ADD_W-1:0] mawb_rd_o,
    output logic [XLEN-1:0]     mawb_val_o
);

    logic            bru_taken;
    logic            bru_toc;
    logic [XLEN-1:0] bru_target;
    logic            take_int;
    logic            take_branch;
    logic            toc_valid;
    logic            pc_we;
    logic            kill;
    logic            we_aux;
    logic            we_val;
    logic            we_esn;
    logic [XLEN-1:0] next_pc;

    ma_control u_control (
        .s_clk_i       (s_clk_i),
        .arst_n_i      (arst_n_i),
        .int_meip_i    (int_meip_i),
        .lsu_ready_i   (lsu_ready_i),
        .exma_ictrl_i  (exma_ictrl_i),
        .bru_taken_i   (bru_taken),
        .bru_toc_i     (bru_toc),
        .mawb_ictrl_i  (mawb_ictrl_o),        // WB state feeds back
        .stall_o       (stall_o),
        .flush_o       (flush_o),
        .hold_o        (hold_o),
        .take_int_o    (take_int),
        .take_branch_o (take_branch),
        .toc_valid_o   (toc_valid),
        .pc_we_o       (pc_we),
        .kill_o        (kill),
        .we_aux_o      (we_aux),
        .we_val_o      (we_val),
        .we_esn_o      (we_esn)
    );

    ma_branch_resolver u_branch_resolver (
        .exma_ictrl_i (exma_ictrl_i),
        .exma_f_i     (exma_f_i),
        .exma_val_i   (exma_val_i),
        .exma_pred_i  (exma_pred_i),
        .bop_tadd_i   (bop_tadd_i),
        .bop_pred_i   (bop_pred_i),
        .kill_i       (kill),                 // No predictor update on dead slots
        .bru_taken_o  (bru_taken),
        .bru_toc_o    (bru_toc),
        .bru_target_o (bru_target),
        .bop_pop_o    (bop_pop_o),
        .pred_btbu_o  (pred_btbu_o),
        .pred_btrue_o (pred_btrue_o),
        .pred_bpu_o   (pred_bpu_o),
        .pred_jpu_o   (pred_jpu_o)
    );

    ma_pc_unit #(
        .TRAP_ADDR (TRAP_ADDR)
    ) u_pc_unit (
        .s_clk_i       (s_clk_i),
        .arst_n_i      (arst_n_i),
        .boot_addr_i   (boot_addr_i),
        .rvc_i         (exma_ictrl_i[ICTRL_RVC]),
        .pc_we_i       (pc_we),
        .take_int_i    (take_int),
        .take_branch_i (take_branch),
        .toc_valid_i   (toc_valid),
        .bru_target_i  (bru_target),
        .pc_o          (pc_o),
        .next_pc_o     (next_pc),
        .toc_addr_o    (toc_addr_o)
    );

    ma_wb_regs u_wb_regs (
        .s_clk_i      (s_clk_i),
        .arst_n_i     (arst_n_i),
        .exma_ictrl_i (exma_ictrl_i),
        .exma_f_i     (exma_f_i),
        .exma_rd_i    (exma_rd_i),
        .exma_val_i   (exma_val_i),
        .lsu_data_i   (lsu_data_i),
        .next_pc_i    (next_pc),
        .kill_i       (kill),
        .we_aux_i     (we_aux),
        .we_val_i     (we_val),
        .we_esn_i     (we_esn),
        .mawb_ictrl_o (mawb_ictrl_o),
        .mawb_rd_o    (mawb_rd_o),
        .mawb_val_o   (mawb_val_o)
    );

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
// Free-running bench clock; reset is released with the last of its cycles on a rising edge
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD     = 100,            // Clock period in ns
    parameter int RST_CYCLES = 3               // Cycles with reset low
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        arst_n_o = 1'b0;                       // Asserted from time zero
        repeat (RST_CYCLES) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/tb_ma_stage.sv
// MA stage bench; EX holds a stalled slot, stimulus from $urandom with seed 13, model in the bench
`timescale 1ns/1ns
`default_nettype none

module tb_ma_stage
    import ma_pkg::*;
();

    localparam int              CLK_PERIOD  = 100;
    localparam int              TEST_CYCLES = 250;                  // Slots per random test
    localparam int              RUN_CYCLES  = 4 * TEST_CYCLES + 10; // Four tests plus reset
    localparam logic [XLEN-1:0] TRAP        = 32'h0000_0240;        // Not the default on purpose
    localparam logic [XLEN-1:0] BOOT        = 32'h0000_1000;

    logic clk, arst_n;
    // DUT inputs, EX side and bus side
    logic [XLEN-1:0] boot_addr, lsu_data, val;
    logic int_meip, lsu_ready, pred, bpred;
    logic [ICTRL_W-1:0] ictrl;
    logic [FUNC_W-1:0] func;
    logic [RF_ADD_W-1:0] rd;
    logic [TAG_W-1:0] tadd;
    // DUT outputs
    logic stall, flush, hold, pop, btbu, btrue, bpu, jpu;
    logic [XLEN-1:0] toc_addr, pc, mawb_val;
    logic [ICTRL_W-1:0] mawb_ictrl;
    logic [RF_ADD_W-1:0] mawb_rd;
    // Model state, what the next edge should register
    logic [XLEN-1:0] m_pc, m_val;
    logic [ICTRL_W-1:0] m_ictrl;
    logic [RF_ADD_W-1:0] m_rd;
    logic held;                                // Slot stalled, EX keeps it
    int checks, errors;

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(3)) u_clock_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    ma_stage #(.TRAP_ADDR(TRAP)) ma_stage_i (
        .s_clk_i (clk), .arst_n_i (arst_n), .boot_addr_i (boot_addr),
        .int_meip_i (int_meip), .lsu_data_i (lsu_data), .lsu_ready_i (lsu_ready),
        .exma_ictrl_i (ictrl), .exma_f_i (func), .exma_rd_i (rd), .exma_val_i (val),
        .exma_pred_i (pred), .bop_tadd_i (tadd), .bop_pred_i (bpred),
        .stall_o (stall), .flush_o (flush), .hold_o (hold), .toc_addr_o (toc_addr),
        .pc_o (pc), .bop_pop_o (pop), .pred_btbu_o (btbu), .pred_btrue_o (btrue),
        .pred_bpu_o (bpu), .pred_jpu_o (jpu), .mawb_ictrl_o (mawb_ictrl),
        .mawb_rd_o (mawb_rd), .mawb_val_o (mawb_val)
    );

    task automatic compare(input string sig, input logic [XLEN-1:0] got,
                           input logic [XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s = %h, expected %h", $time, sig, got, exp);
        end
    endtask

    // Shift the addressed lane down, then extend it by the load type
    function automatic logic [XLEN-1:0] extend_load(input logic [FUNC_W-1:0] f,
                                                    input logic [1:0] off,
                                                    input logic [XLEN-1:0] word);
        logic [XLEN-1:0] lane_b;
        logic [XLEN-1:0] lane_h;
        lane_b = word >> (8 * off);
        lane_h = word >> (off[1] ? 16 : 0);    // Halfword lane from bit 1 only
        case (f)
            LD_LB:   return {{24{lane_b[7]}}, lane_b[7:0]};
            LD_LH:   return {{16{lane_h[15]}}, lane_h[15:0]};
            LD_LBU:  return {24'd0, lane_b[7:0]};
            LD_LHU:  return {16'd0, lane_h[15:0]};
            default: return word;              // LW
        endcase
    endfunction

    // Kind 0 ALU/MDU/empty, 1 BRU, 2 LSU, 3 mix with interrupts
    task automatic drive_slot(input int kind);
        logic [ICTRL_W-1:0] ctrl;
        logic [FUNC_W-1:0]  fn;
        logic [XLEN-1:0]    v;
        int                 unit;
        int                 pick;
        lsu_ready <= ($urandom_range(0, 2) != 0);        // Ready two cycles in three
        lsu_data  <= $urandom;
        int_meip  <= (kind == 3) && ($urandom_range(0, 3) == 0);
        if (!held) begin
            pick = $urandom_range(0, 3);
            unit = ICTRL_UNIT_ALU;
            if (kind == 1 || (kind == 3 && pick == 1)) unit = ICTRL_UNIT_BRU;
            else if (kind == 2 || (kind == 3 && pick == 2)) unit = ICTRL_UNIT_LSU;
            else if (kind == 0 && pick == 2) unit = ICTRL_UNIT_MDU;
            ctrl = '0;
            if (!((kind == 0 || kind == 3) && pick == 0)) begin   // Pick 0 leaves it empty
                ctrl = ICTRL_W'(1) << unit;
                ctrl[ICTRL_RVC] = ($urandom_range(0, 1) == 1);
                ctrl[ICTRL_REG_DEST] = ($urandom_range(0, 1) == 1);
            end
            v = $urandom;
            if (unit == ICTRL_UNIT_LSU) begin
                case ($urandom_range(0, 4))
                    0: fn = LD_LB;
                    1: fn = LD_LH;
                    2: fn = LD_LW;
                    3: fn = LD_LBU;
                    default: fn = LD_LHU;
                endcase
            end else if (unit == ICTRL_UNIT_BRU && $urandom_range(0, 1) == 1) begin
                fn = BRU_F_BRANCH;
            end else begin
                fn = FUNC_W'($urandom_range(1, 7));          // Jump on a BRU slot
            end
            ictrl <= ctrl;
            func  <= fn;
            rd    <= RF_ADD_W'($urandom);
            val   <= v;
            pred  <= ($urandom_range(0, 1) == 1);
            bpred <= ($urandom_range(0, 1) == 1);
            tadd  <= ($urandom_range(0, 1) == 1) ? v[XLEN-1:1] : TAG_W'($urandom);
        end
    endtask

    // Sampled on the falling edge, when inputs and registers are settled
    task automatic check_and_step();
        logic is_lsu, is_bru, is_branch, empty_slot, stall_e, int_e;
        logic taken, predicted, miss, toc, live, kill_e, we_pc;
        logic [XLEN-1:0] seq_pc, new_pc;
        logic [4:0] strobes;
        compare("pc_o", pc, m_pc);                       // Result of the previous slot
        compare("mawb_ictrl_o", XLEN'(mawb_ictrl), XLEN'(m_ictrl));
        if (m_ictrl != '0) begin
            compare("mawb_rd_o", XLEN'(mawb_rd), XLEN'(m_rd));
            compare("mawb_val_o", mawb_val, m_val);
        end
        is_lsu     = ictrl[ICTRL_UNIT_LSU];
        is_bru     = ictrl[ICTRL_UNIT_BRU];
        is_branch  = (func == BRU_F_BRANCH);
        empty_slot = (ictrl == '0);
        stall_e    = is_lsu && !lsu_ready;
        int_e      = int_meip && !is_lsu;                // Interrupt waits on a bus transfer
        taken      = is_branch ? val[0] : 1'b1;
        predicted  = pred && bpred;
        miss       = (tadd != val[XLEN-1:1]);
        toc        = is_bru && ((taken != predicted) || (taken && predicted && miss));
        kill_e     = int_e || stall_e;
        live       = is_bru && !kill_e;
        strobes    = {live && pred, live && taken && (!predicted || miss),
                      live && is_branch && taken, live && is_branch, live && !is_branch};
        seq_pc = m_pc + (ictrl[ICTRL_RVC] ? 32'd2 : 32'd4);
        if (int_e) new_pc = TRAP;
        else if (is_bru && taken) new_pc = {val[XLEN-1:1], 1'b0};
        else new_pc = seq_pc;
        we_pc = (!empty_slot && !stall_e) || int_e;
        compare("stall_o", XLEN'(stall), XLEN'(stall_e));
        compare("flush_o", XLEN'(flush), XLEN'(int_e || toc));
        compare("hold_o", XLEN'(hold), XLEN'(int_meip));
        compare("toc_addr_o", toc_addr, we_pc ? new_pc : m_pc);
        compare("{bop_pop_o,pred_btbu_o,pred_btrue_o,pred_bpu_o,pred_jpu_o}",
                XLEN'({pop, btbu, btrue, bpu, jpu}), XLEN'(strobes));
        if (we_pc) m_pc = new_pc;
        m_ictrl = kill_e ? '0 : ictrl;                   // Bubble on stall or interrupt
        if (!kill_e && !empty_slot) begin
            m_rd = rd;
            if (is_lsu) m_val = extend_load(func, val[1:0], lsu_data);
            else if (is_bru) m_val = seq_pc;             // Link address
            else m_val = val;
        end
        held = stall_e;
    endtask

    task automatic run_test(input string name, input int kind, input int cycles);
        int chk0;
        int err0;
        chk0 = checks;
        err0 = errors;
        for (int n = 0; n < cycles; n++) begin
            @(posedge clk);
            drive_slot(kind);
            @(negedge clk);
            check_and_step();
        end
        $display("Test %s: %0d checks, %0d errors", name, checks - chk0, errors - err0);
    endtask

    initial begin
        void'($urandom(13));                   // Seeds the generator once
        boot_addr = BOOT;
        int_meip  = 1'b0;
        lsu_data  = '0;
        lsu_ready = 1'b0;
        ictrl     = '0;
        func      = '0;
        rd        = '0;
        val       = '0;
        pred      = 1'b0;
        tadd      = '0;
        bpred     = 1'b0;
        held      = 1'b0;
        checks    = 0;
        errors    = 0;
        m_pc      = BOOT;
        m_ictrl   = '0;
        m_rd      = '0;
        m_val     = '0;
        wait (arst_n === 1'b1);
        @(negedge clk);
        compare("pc_o", pc, BOOT);             // Empty inputs right after reset
        compare("mawb_ictrl_o", XLEN'(mawb_ictrl), '0);
        compare("flush_o", XLEN'(flush), '0);
        compare("stall_o", XLEN'(stall), '0);
        $display("Test reset: %0d checks, %0d errors", checks, errors);
        run_test("alu_mdu", 0, TEST_CYCLES);
        run_test("branch", 1, TEST_CYCLES);
        run_test("load", 2, TEST_CYCLES);
        run_test("interrupt", 3, TEST_CYCLES);
        $display("Total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Run length plus twenty cycles of margin
    initial begin
        #(RUN_CYCLES * CLK_PERIOD + 20 * CLK_PERIOD);
        $display("Watchdog expired at %0t ns, the tests did not finish", $time);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
design/ma_pkg.sv
design/load_extender.sv
design/ma_control.sv
design/ma_branch_resolver.sv
design/ma_pc_unit.sv
design/ma_wb_regs.sv
design/ma_stage.sv
verification/tb_clock_gen.sv
verification/tb_ma_stage.sv

//--- run_sim.sh
#!/bin/sh
# Builds the MA stage testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f project.f --top-module tb_ma_stage \
    -Mdir obj_dir -o sim_ma_stage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_ma_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^All checks passed$" "$LOG"; then
    echo "Result: PASS"
    exit 0
else
    echo "Result: FAIL"
    exit 1
fi
